/* mipsPkg.sv */
package mipsPkg;

    // -------------------------------------------------------------------------
    // Widths and memory sizes
    // -------------------------------------------------------------------------
    localparam int DataWidth     = 32;
    localparam int RegAddrWidth  = 5;
    localparam int ImemDepth     = 64;
    localparam int ImemAddrWidth = 6;
    localparam int DmemDepth     = 64;
    localparam int DmemAddrWidth = 6;

    // -------------------------------------------------------------------------
    // Instruction encodings
    // -------------------------------------------------------------------------
    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        RType = 6'h00,
        J     = 6'h02,
        Beq   = 6'h04,
        Bne   = 6'h05,
        Addiu = 6'h09,
        Ori   = 6'h0d,
        Lui   = 6'h0f,
        Lw    = 6'h23,
        Sw    = 6'h2b
    } opcodeT;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        Sll  = 6'h00,
        Addu = 6'h21,
        Subu = 6'h23,
        And  = 6'h24,
        Or   = 6'h25,
        Slt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt,
        AluSll,
        AluLui
    } aluOpT;

    typedef enum logic {
        WbAlu,
        WbMem
    } wbSelT;

endpackage

/* mipsFetch.sv */
`timescale 1ns/1ps

module mipsFetch (
    input  logic                               clock,
    input  logic                               arstN,
    input  logic                               run,
    input  logic                               stall,
    input  logic                               redirect,
    input  logic [mipsPkg::DataWidth-1:0]      redirectPc,
    input  logic                               progWrEn,
    input  logic [mipsPkg::ImemAddrWidth-1:0]  progAddr,
    input  logic [mipsPkg::DataWidth-1:0]      progData,
    output logic [mipsPkg::DataWidth-1:0]      instruction,
    output logic [mipsPkg::DataWidth-1:0]      pcPlus4
);

    logic [mipsPkg::DataWidth-1:0] imem [mipsPkg::ImemDepth];
    logic [mipsPkg::DataWidth-1:0] pc;
    logic [mipsPkg::DataWidth-1:0] pcNext;

    // Program load while the core is idle
    always_ff @(posedge clock) begin
        if (progWrEn) begin
            imem[progAddr] <= progData;
        end
    end

    assign pcNext = pc + 32'd4;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= redirect ? redirectPc : pcNext;
        end
    end

    // IF/ID register, a zero word is a NOP
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            instruction <= '0;
            pcPlus4     <= '0;
        end else if (!run) begin
            instruction <= '0;
            pcPlus4     <= '0;
        end else if (!stall) begin
            instruction <= imem[pc[mipsPkg::ImemAddrWidth+1:2]];
            pcPlus4     <= pcNext;
        end
    end

endmodule

/* mipsDecode.sv */
`timescale 1ns/1ps

module mipsDecode (
    input  logic                              clock,
    input  logic                              arstN,
    input  logic [mipsPkg::DataWidth-1:0]     instruction,
    input  logic [mipsPkg::DataWidth-1:0]     pcPlus4,
    input  logic                              wbEn,
    input  logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    input  logic [mipsPkg::DataWidth-1:0]     wbData,
    input  logic                              memMemRead,
    input  logic [mipsPkg::RegAddrWidth-1:0]  memWriteReg,
    input  logic                              fwdBranchA,
    input  logic                              fwdBranchB,
    input  logic [mipsPkg::DataWidth-1:0]     memAluResult,
    output logic                              stall,
    output logic                              redirect,
    output logic [mipsPkg::DataWidth-1:0]     redirectPc,
    output logic [mipsPkg::RegAddrWidth-1:0]  idRs,
    output logic [mipsPkg::RegAddrWidth-1:0]  idRt,
    output logic [mipsPkg::DataWidth-1:0]     exOpA,
    output logic [mipsPkg::DataWidth-1:0]     exOpB,
    output logic [mipsPkg::DataWidth-1:0]     exImm,
    output logic [4:0]                        exShamt,
    output logic [mipsPkg::RegAddrWidth-1:0]  exRs,
    output logic [mipsPkg::RegAddrWidth-1:0]  exRt,
    output logic [mipsPkg::RegAddrWidth-1:0]  exWriteReg,
    output mipsPkg::aluOpT                    exAluOp,
    output logic                              exAluSrcImm,
    output logic                              exRegWrite,
    output logic                              exMemRead,
    output logic                              exMemWrite,
    output mipsPkg::wbSelT                    exWbSel
);

    logic [mipsPkg::DataWidth-1:0]    regFile [2**mipsPkg::RegAddrWidth];
    mipsPkg::opcodeT                  opcode;
    mipsPkg::functT                   funct;
    logic [mipsPkg::RegAddrWidth-1:0] rd;
    logic [mipsPkg::RegAddrWidth-1:0] destReg;
    logic [mipsPkg::DataWidth-1:0]    signImm, zeroImm, imm;
    logic [mipsPkg::DataWidth-1:0]    rdA, rdB, brA, brB;
    mipsPkg::aluOpT                   aluOp;
    mipsPkg::wbSelT                   wbSel;
    logic aluSrcImm, regWrite, memRead, memWrite;
    logic usesRs, usesRt, isBranch, isJump, branchTaken;
    logic loadUse, branchOnEx, branchOnMem;

    assign opcode  = mipsPkg::opcodeT'(instruction[31:26]);
    assign funct   = mipsPkg::functT'(instruction[5:0]);
    assign idRs    = instruction[25:21];
    assign idRt    = instruction[20:16];
    assign rd      = instruction[15:11];
    assign signImm = {{16{instruction[15]}}, instruction[15:0]};
    assign zeroImm = {16'b0, instruction[15:0]};

    // -------------------------------------------------------------------------
    // Register file, write first
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (wbEn && wbReg != '0) begin
            regFile[wbReg] <= wbData;
        end
    end

    assign rdA = (idRs == '0) ? '0 : (wbEn && wbReg == idRs) ? wbData : regFile[idRs];
    assign rdB = (idRt == '0) ? '0 : (wbEn && wbReg == idRt) ? wbData : regFile[idRt];

    // -------------------------------------------------------------------------
    // Control decode
    // -------------------------------------------------------------------------
    always_comb begin
        aluOp     = mipsPkg::AluAdd;
        wbSel     = mipsPkg::WbAlu;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        destReg   = idRt;
        imm       = signImm;
        usesRt    = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        case (opcode)
            mipsPkg::RType: begin
                destReg  = rd;
                usesRt   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    mipsPkg::Sll:  aluOp = mipsPkg::AluSll;
                    mipsPkg::Addu: aluOp = mipsPkg::AluAdd;
                    mipsPkg::Subu: aluOp = mipsPkg::AluSub;
                    mipsPkg::And:  aluOp = mipsPkg::AluAnd;
                    mipsPkg::Or:   aluOp = mipsPkg::AluOr;
                    mipsPkg::Slt:  aluOp = mipsPkg::AluSlt;
                    default:       regWrite = 1'b0;
                endcase
            end
            mipsPkg::Addiu: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            mipsPkg::Ori: begin
                aluOp     = mipsPkg::AluOr;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                imm       = zeroImm;
            end
            mipsPkg::Lui: begin
                aluOp     = mipsPkg::AluLui;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                imm       = zeroImm;
            end
            mipsPkg::Lw: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                memRead   = 1'b1;
                wbSel     = mipsPkg::WbMem;
            end
            mipsPkg::Sw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                usesRt    = 1'b1;
            end
            mipsPkg::Beq, mipsPkg::Bne: begin
                isBranch = 1'b1;
                usesRt   = 1'b1;
            end
            mipsPkg::J: isJump = 1'b1;
            default: ;
        endcase
    end

    assign usesRs = (opcode != mipsPkg::Lui) && (opcode != mipsPkg::J);

    // -------------------------------------------------------------------------
    // Hazards
    // -------------------------------------------------------------------------
    assign loadUse = exMemRead && exWriteReg != '0
                     && ((usesRs && exWriteReg == idRs) || (usesRt && exWriteReg == idRt));
    assign branchOnEx = isBranch && exRegWrite && exWriteReg != '0
                        && (exWriteReg == idRs || exWriteReg == idRt);
    // Load result not ready for the comparator until WB
    assign branchOnMem = isBranch && memMemRead && memWriteReg != '0
                         && (memWriteReg == idRs || memWriteReg == idRt);
    assign stall = loadUse || branchOnEx || branchOnMem;

    // Branch and jump resolution
    assign brA = fwdBranchA ? memAluResult : rdA;
    assign brB = fwdBranchB ? memAluResult : rdB;
    assign branchTaken = isBranch && ((opcode == mipsPkg::Beq) ? (brA == brB) : (brA != brB));
    assign redirect    = !stall && (branchTaken || isJump);
    assign redirectPc  = isJump ? {pcPlus4[31:28], instruction[25:0], 2'b00}
                                : pcPlus4 + {signImm[mipsPkg::DataWidth-3:0], 2'b00};

    // ID/EX register, a stall loads a bubble
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exRegWrite <= regWrite && !stall;
            exMemRead  <= memRead && !stall;
            exMemWrite <= memWrite && !stall;
        end
    end

    always_ff @(posedge clock) begin
        exOpA       <= rdA;
        exOpB       <= rdB;
        exImm       <= imm;
        exShamt     <= instruction[10:6];
        exRs        <= idRs;
        exRt        <= idRt;
        exWriteReg  <= destReg;
        exAluOp     <= aluOp;
        exAluSrcImm <= aluSrcImm;
        exWbSel     <= wbSel;
    end

endmodule

/* mipsForward.sv */
`timescale 1ns/1ps

module mipsForward (
    input  logic [mipsPkg::RegAddrWidth-1:0] idRs,
    input  logic [mipsPkg::RegAddrWidth-1:0] idRt,
    input  logic [mipsPkg::RegAddrWidth-1:0] exRs,
    input  logic [mipsPkg::RegAddrWidth-1:0] exRt,
    input  logic                             memRegWrite,
    input  logic [mipsPkg::RegAddrWidth-1:0] memWriteReg,
    input  logic                             wbEn,
    input  logic [mipsPkg::RegAddrWidth-1:0] wbReg,
    output logic [1:0]                       fwdA,
    output logic [1:0]                       fwdB,
    output logic                             fwdBranchA,
    output logic                             fwdBranchB
);

    logic memHit, wbHit;

    // Producers that can forward at all
    assign memHit = memRegWrite && memWriteReg != '0;
    assign wbHit  = wbEn && wbReg != '0;

    // 0 register file, 1 EX/MEM, 2 MEM/WB
    assign fwdA = (memHit && memWriteReg == exRs) ? 2'd1 :
                  (wbHit && wbReg == exRs)        ? 2'd2 : 2'd0;
    assign fwdB = (memHit && memWriteReg == exRt) ? 2'd1 :
                  (wbHit && wbReg == exRt)        ? 2'd2 : 2'd0;

    // MEM/WB already reaches ID through the write-first register file
    assign fwdBranchA = memHit && memWriteReg == idRs;
    assign fwdBranchB = memHit && memWriteReg == idRt;

endmodule

/* mipsExecute.sv */
`timescale 1ns/1ps

module mipsExecute (
    input  logic                              clock,
    input  logic                              arstN,
    input  logic [mipsPkg::DataWidth-1:0]     exOpA,
    input  logic [mipsPkg::DataWidth-1:0]     exOpB,
    input  logic [mipsPkg::DataWidth-1:0]     exImm,
    input  logic [4:0]                        exShamt,
    input  logic [mipsPkg::RegAddrWidth-1:0]  exWriteReg,
    input  mipsPkg::aluOpT                    exAluOp,
    input  logic                              exAluSrcImm,
    input  logic                              exRegWrite,
    input  logic                              exMemRead,
    input  logic                              exMemWrite,
    input  mipsPkg::wbSelT                    exWbSel,
    input  logic [1:0]                        fwdA,
    input  logic [1:0]                        fwdB,
    input  logic [mipsPkg::DataWidth-1:0]     wbData,
    output logic [mipsPkg::DataWidth-1:0]     memAluResult,
    output logic [mipsPkg::DataWidth-1:0]     memStoreData,
    output logic [mipsPkg::RegAddrWidth-1:0]  memWriteReg,
    output logic                              memRegWrite,
    output logic                              memMemRead,
    output logic                              memMemWrite,
    output mipsPkg::wbSelT                    memWbSel
);

    logic [mipsPkg::DataWidth-1:0] srcA, regB, srcB, aluResult;

    // Operand forwarding
    assign srcA = (fwdA == 2'd1) ? memAluResult : (fwdA == 2'd2) ? wbData : exOpA;
    assign regB = (fwdB == 2'd1) ? memAluResult : (fwdB == 2'd2) ? wbData : exOpB;
    assign srcB = exAluSrcImm ? exImm : regB;

    always_comb begin
        case (exAluOp)
            mipsPkg::AluAdd: aluResult = srcA + srcB;
            mipsPkg::AluSub: aluResult = srcA - srcB;
            mipsPkg::AluAnd: aluResult = srcA & srcB;
            mipsPkg::AluOr:  aluResult = srcA | srcB;
            mipsPkg::AluSlt: begin
                aluResult = {{(mipsPkg::DataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            end
            // Shift amount from the instruction, value from rt
            mipsPkg::AluSll: aluResult = srcB << exShamt;
            mipsPkg::AluLui: aluResult = {srcB[15:0], 16'b0};
            default:         aluResult = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clock) begin
        memAluResult <= aluResult;
        memStoreData <= regB;
        memWriteReg  <= exWriteReg;
        memWbSel     <= exWbSel;
    end

endmodule

/* mipsMemory.sv */
`timescale 1ns/1ps

module mipsMemory (
    input  logic                              clock,
    input  logic                              arstN,
    input  logic [mipsPkg::DataWidth-1:0]     memAluResult,
    input  logic [mipsPkg::DataWidth-1:0]     memStoreData,
    input  logic [mipsPkg::RegAddrWidth-1:0]  memWriteReg,
    input  logic                              memRegWrite,
    input  logic                              memMemRead,
    input  logic                              memMemWrite,
    input  mipsPkg::wbSelT                    memWbSel,
    output logic                              storeValid,
    output logic [mipsPkg::DataWidth-1:0]     storeAddr,
    output logic [mipsPkg::DataWidth-1:0]     storeData,
    output logic                              wbEn,
    output logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::DataWidth-1:0]     wbAluResult,
    output logic [mipsPkg::DataWidth-1:0]     wbMemData,
    output mipsPkg::wbSelT                    wbSel
);

    logic [mipsPkg::DataWidth-1:0]     dmem [mipsPkg::DmemDepth];
    logic [mipsPkg::DmemAddrWidth-1:0] wordAddr;

    // Word addressed, low byte bits ignored
    assign wordAddr = memAluResult[mipsPkg::DmemAddrWidth+1:2];

    always_ff @(posedge clock) begin
        if (memMemWrite) begin
            dmem[wordAddr] <= memStoreData;
        end
    end

    // Store observation
    assign storeValid = memMemWrite;
    assign storeAddr  = memAluResult;
    assign storeData  = memStoreData;

    // MEM/WB register
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= memRegWrite;
        end
    end

    always_ff @(posedge clock) begin
        wbReg       <= memWriteReg;
        wbAluResult <= memAluResult;
        wbMemData   <= memMemRead ? dmem[wordAddr] : '0;
        wbSel       <= memWbSel;
    end

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
    input  logic                               clock,
    input  logic                               arstN,
    input  logic                               progWrEn,
    input  logic [mipsPkg::ImemAddrWidth-1:0]  progAddr,
    input  logic [mipsPkg::DataWidth-1:0]      progData,
    input  logic                               run,
    output logic                               retireValid,
    output logic [mipsPkg::RegAddrWidth-1:0]   retireReg,
    output logic [mipsPkg::DataWidth-1:0]      retireData,
    output logic                               storeValid,
    output logic [mipsPkg::DataWidth-1:0]      storeAddr,
    output logic [mipsPkg::DataWidth-1:0]      storeData
);

    // -------------------------------------------------------------------------
    // Stage interconnect
    // -------------------------------------------------------------------------
    logic [mipsPkg::DataWidth-1:0]    instruction, pcPlus4, redirectPc;
    logic                             stall, redirect;
    logic [mipsPkg::RegAddrWidth-1:0] idRs, idRt, exRs, exRt, exWriteReg;
    logic [mipsPkg::DataWidth-1:0]    exOpA, exOpB, exImm;
    logic [4:0]                       exShamt;
    mipsPkg::aluOpT                   exAluOp;
    mipsPkg::wbSelT                   exWbSel, memWbSel, wbSel;
    logic exAluSrcImm, exRegWrite, exMemRead, exMemWrite;
    logic [1:0]                       fwdA, fwdB;
    logic                             fwdBranchA, fwdBranchB;
    logic [mipsPkg::DataWidth-1:0]    memAluResult, memStoreData;
    logic [mipsPkg::RegAddrWidth-1:0] memWriteReg, wbReg;
    logic memRegWrite, memMemRead, memMemWrite, wbEn;
    logic [mipsPkg::DataWidth-1:0]    wbAluResult, wbMemData, wbData;

    mipsFetch i_fetch (
        .clock, .arstN, .run, .stall, .redirect, .redirectPc,
        .progWrEn, .progAddr, .progData, .instruction, .pcPlus4
    );

    mipsDecode i_decode (
        .clock, .arstN, .instruction, .pcPlus4, .wbEn, .wbReg, .wbData,
        .memMemRead, .memWriteReg, .fwdBranchA, .fwdBranchB, .memAluResult,
        .stall, .redirect, .redirectPc, .idRs, .idRt,
        .exOpA, .exOpB, .exImm, .exShamt, .exRs, .exRt, .exWriteReg,
        .exAluOp, .exAluSrcImm, .exRegWrite, .exMemRead, .exMemWrite, .exWbSel
    );

    mipsForward i_forward (
        .idRs, .idRt, .exRs, .exRt, .memRegWrite, .memWriteReg, .wbEn, .wbReg,
        .fwdA, .fwdB, .fwdBranchA, .fwdBranchB
    );

    mipsExecute i_execute (
        .clock, .arstN, .exOpA, .exOpB, .exImm, .exShamt, .exWriteReg,
        .exAluOp, .exAluSrcImm, .exRegWrite, .exMemRead, .exMemWrite, .exWbSel,
        .fwdA, .fwdB, .wbData,
        .memAluResult, .memStoreData, .memWriteReg, .memRegWrite,
        .memMemRead, .memMemWrite, .memWbSel
    );

    mipsMemory i_memory (
        .clock, .arstN, .memAluResult, .memStoreData, .memWriteReg,
        .memRegWrite, .memMemRead, .memMemWrite, .memWbSel,
        .storeValid, .storeAddr, .storeData,
        .wbEn, .wbReg, .wbAluResult, .wbMemData, .wbSel
    );

    // Write-back select
    assign wbData = (wbSel == mipsPkg::WbMem) ? wbMemData : wbAluResult;

    // Retire only real register writes
    assign retireValid = wbEn && wbReg != '0;
    assign retireReg   = wbReg;
    assign retireData  = wbData;

endmodule

/* mipsCore_asserts.sv */
`timescale 1ns/1ps

module mipsCore_asserts (
    input logic                             clock,
    input logic                             arstN,
    input logic                             run,
    input logic                             stall,
    input logic [mipsPkg::DataWidth-1:0]    pc,
    input logic                             retireValid,
    input logic [mipsPkg::DataWidth-1:0]    retireData,
    input logic                             storeValid
);

    int unsigned failCount = 0;

    // Retired values come from written registers or stored words
    assert property (@(posedge clock) disable iff (!arstN)
                     retireValid |-> !$isunknown(retireData))
        else begin
            $error("retired data is unknown");
            failCount++;
        end

    // A store reaches WB without a register write
    assert property (@(posedge clock) disable iff (!arstN) storeValid |=> !retireValid)
        else begin
            $error("store instruction retired a register");
            failCount++;
        end

    assert property (@(posedge clock) disable iff (!arstN) (run && stall) |=> $stable(pc))
        else begin
            $error("PC moved during a decode stall");
            failCount++;
        end

    assert property (@(posedge clock) !arstN |-> !retireValid && !storeValid)
        else begin
            $error("retire or store active during reset");
            failCount++;
        end

endmodule

bind mipsCore mipsCore_asserts i_asserts (
    .clock, .arstN, .run, .stall, .pc(i_fetch.pc), .retireValid, .retireData, .storeValid
);

/* mipsTb.sv */
`timescale 1ns/1ps

module mipsTb;

    logic                               clock = 1'b0;
    logic                               arstN;
    logic                               run;
    logic                               progWrEn;
    logic [mipsPkg::ImemAddrWidth-1:0]  progAddr;
    logic [mipsPkg::DataWidth-1:0]      progData;
    logic                               retireValid;
    logic [mipsPkg::RegAddrWidth-1:0]   retireReg;
    logic [mipsPkg::DataWidth-1:0]      retireData;
    logic                               storeValid;
    logic [mipsPkg::DataWidth-1:0]      storeAddr;
    logic [mipsPkg::DataWidth-1:0]      storeData;

    logic [31:0] progWords [mipsPkg::ImemDepth];
    logic [31:0] expRetireReg [$];
    logic [31:0] expRetireData [$];
    logic [31:0] expStoreAddr [$];
    logic [31:0] expStoreData [$];
    logic [31:0] lcgState = 32'd17;

    mipsCore i_dut (
        .clock, .arstN, .progWrEn, .progAddr, .progData, .run,
        .retireValid, .retireReg, .retireData, .storeValid, .storeAddr, .storeData
    );

    always #5 clock = ~clock;

    // Bound pipeline assertions
    always @(negedge clock) begin
        if (i_dut.i_asserts.failCount != 0) begin
            abortRun("a concurrent assertion in mipsCore_asserts failed");
        end
    end

    // ------------------------------------------------------------------------
    // Encoders and helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] shamt,
                                         input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Target is a word index
    function automatic logic [31:0] encJ(input int target);
        return {6'h02, 26'(target)};
    endfunction

    // 15-bit value from the LCG, positive after sign extension
    function automatic logic [15:0] randomImm();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {1'b0, lcgState[30:16]};
    endfunction

    task automatic nextDriveSlot();
        @(posedge clock);
        #1;
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkEqual(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("error: time %0t: %s is 0x%08h, expected 0x%08h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic newProgram();
        foreach (progWords[i]) progWords[i] = '0;
        expRetireReg.delete();
        expRetireData.delete();
        expStoreAddr.delete();
        expStoreData.delete();
    endtask

    task automatic expectRetire(input logic [4:0] regIdx, input logic [31:0] data);
        expRetireReg.push_back({27'b0, regIdx});
        expRetireData.push_back(data);
    endtask

    // Load all words, run, and compare events in program order
    task automatic runProgram(input int timeout);
        int retIdx;
        int stIdx;
        int cycles;
        retIdx = 0;
        stIdx  = 0;
        cycles = 0;
        for (int i = 0; i < mipsPkg::ImemDepth; i++) begin
            nextDriveSlot();
            progWrEn = 1'b1;
            progAddr = i[mipsPkg::ImemAddrWidth-1:0];
            progData = progWords[i];
        end
        nextDriveSlot();
        progWrEn = 1'b0;
        run      = 1'b1;
        while (retIdx < expRetireReg.size() || stIdx < expStoreAddr.size()) begin
            if (cycles == timeout) begin
                abortRun("timeout: the expected retire and store events did not all arrive");
            end
            @(negedge clock);
            cycles++;
            if (retireValid) begin
                if (retIdx >= expRetireReg.size()) begin
                    abortRun($sformatf("unexpected retire of register %0d", retireReg));
                end
                checkEqual("retire register", {27'b0, retireReg}, expRetireReg[retIdx]);
                checkEqual("retire data", retireData, expRetireData[retIdx]);
                retIdx++;
            end
            if (storeValid) begin
                if (stIdx >= expStoreAddr.size()) begin
                    abortRun("unexpected store on the store port");
                end
                checkEqual("store address", storeAddr, expStoreAddr[stIdx]);
                checkEqual("store data", storeData, expStoreData[stIdx]);
                stIdx++;
            end
        end
        // Program ends in a self jump, so nothing more may appear
        repeat (8) begin
            @(negedge clock);
            if (retireValid || storeValid) begin
                abortRun("an extra retire or store appeared after the last expected one");
            end
        end
        nextDriveSlot();
        run = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic aluChainTest();
        logic [31:0] r [11];
        newProgram();
        r[1]  = {16'b0, randomImm()};
        r[2]  = {16'b0, randomImm()};
        r[3]  = r[1] + r[2];
        r[4]  = r[1] - r[3];
        r[5]  = r[4] & r[3];
        r[6]  = r[5] | r[2];
        r[7]  = ($signed(r[4]) < $signed(r[6])) ? 32'd1 : 32'd0;
        r[8]  = r[6] << 3;
        r[9]  = r[8] | 32'h0000_1234;
        r[10] = 32'habcd_0000;
        progWords[0]  = encI(mipsPkg::Addiu, 0, 1, r[1][15:0]);
        progWords[1]  = encI(mipsPkg::Addiu, 0, 2, r[2][15:0]);
        progWords[2]  = encR(1, 2, 3, 0, mipsPkg::Addu);
        progWords[3]  = encR(1, 3, 4, 0, mipsPkg::Subu);
        progWords[4]  = encR(4, 3, 5, 0, mipsPkg::And);
        progWords[5]  = encR(5, 2, 6, 0, mipsPkg::Or);
        progWords[6]  = encR(4, 6, 7, 0, mipsPkg::Slt);
        progWords[7]  = encR(0, 6, 8, 3, mipsPkg::Sll);
        progWords[8]  = encI(mipsPkg::Ori, 8, 9, 16'h1234);
        progWords[9]  = encI(mipsPkg::Lui, 0, 10, 16'habcd);
        progWords[10] = encJ(10);
        for (int i = 1; i <= 10; i++) expectRetire(i[4:0], r[i]);
        runProgram(100);
    endtask

    task automatic storeLoadTest();
        logic [31:0] v;
        newProgram();
        v = {16'b0, randomImm()};
        progWords[0] = encI(mipsPkg::Addiu, 0, 1, 16'h0040);
        progWords[1] = encI(mipsPkg::Addiu, 0, 2, v[15:0]);
        progWords[2] = encI(mipsPkg::Sw, 1, 2, 16'd4);
        progWords[3] = encI(mipsPkg::Lw, 1, 3, 16'd4);
        // Uses the load result right away
        progWords[4] = encR(3, 1, 4, 0, mipsPkg::Addu);
        progWords[5] = encJ(5);
        expectRetire(1, 32'h40);
        expectRetire(2, v);
        expectRetire(3, v);
        expectRetire(4, v + 32'h40);
        expStoreAddr.push_back(32'h44);
        expStoreData.push_back(v);
        runProgram(100);
    endtask

    task automatic branchTest();
        newProgram();
        progWords[0] = encI(mipsPkg::Addiu, 0, 1, 16'd5);
        progWords[1] = encI(mipsPkg::Addiu, 0, 2, 16'd5);
        progWords[2] = encI(mipsPkg::Beq, 1, 2, 16'd2);
        progWords[3] = encI(mipsPkg::Addiu, 0, 3, 16'd7);
        progWords[4] = encI(mipsPkg::Addiu, 0, 4, 16'd9);
        progWords[5] = encI(mipsPkg::Bne, 1, 2, 16'd2);
        progWords[6] = encI(mipsPkg::Addiu, 0, 5, 16'd11);
        progWords[7] = encI(mipsPkg::Addiu, 0, 6, 16'd13);
        progWords[8] = encI(mipsPkg::Addiu, 0, 7, 16'd15);
        progWords[9] = encJ(9);
        expectRetire(1, 32'd5);
        expectRetire(2, 32'd5);
        expectRetire(3, 32'd7);
        expectRetire(5, 32'd11);
        expectRetire(6, 32'd13);
        expectRetire(7, 32'd15);
        runProgram(100);
    endtask

    task automatic jumpTest();
        newProgram();
        progWords[0] = encI(mipsPkg::Addiu, 0, 1, 16'd1);
        progWords[1] = encJ(5);
        progWords[2] = encI(mipsPkg::Addiu, 0, 2, 16'd2);
        progWords[3] = encI(mipsPkg::Addiu, 0, 3, 16'd3);
        progWords[4] = encI(mipsPkg::Addiu, 0, 4, 16'd4);
        progWords[5] = encR(1, 2, 5, 0, mipsPkg::Addu);
        progWords[6] = encJ(6);
        expectRetire(1, 32'd1);
        expectRetire(2, 32'd2);
        expectRetire(5, 32'd3);
        runProgram(100);
    endtask

    task automatic zeroRegTest();
        newProgram();
        progWords[0] = encI(mipsPkg::Addiu, 0, 0, 16'h0055);
        progWords[1] = encR(0, 0, 1, 0, mipsPkg::Addu);
        progWords[2] = encI(mipsPkg::Addiu, 0, 2, 16'd3);
        progWords[3] = encJ(3);
        expectRetire(1, 32'd0);
        expectRetire(2, 32'd3);
        runProgram(100);
    endtask

    initial begin
        arstN    = 1'b0;
        run      = 1'b0;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        repeat (10) @(posedge clock);
        #1;
        arstN = 1'b1;
        aluChainTest();
        storeLoadTest();
        branchTest();
        jumpTest();
        zeroRegTest();
        if (i_dut.i_asserts.failCount == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abortRun("a concurrent assertion in mipsCore_asserts failed");
        end
    end

endmodule

/* list.f */
mipsPkg.sv
mipsFetch.sv
mipsDecode.sv
mipsForward.sv
mipsExecute.sv
mipsMemory.sv
mipsCore.sv
mipsCore_asserts.sv
mipsTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - mipsPkg.sv
  - mipsFetch.sv
  - mipsDecode.sv
  - mipsForward.sv
  - mipsExecute.sv
  - mipsMemory.sv
  - mipsCore.sv
  - target: test
    files:
      - mipsCore_asserts.sv
      - mipsTb.sv
